//--- list.f
+incdir+tests
src/wfd_pkg.sv
src/trigger_manager.sv
src/stream_fifo.sv
src/channel_tx_router.sv
src/channel_rx_arbiter.sv
src/wfd_master_core.sv
tests/tb_wfd_master_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the wfd_master_core testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_wfd_master_core \
    -f list.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "simulation FAILED, see $LOG"
    exit 1
fi

echo "simulation PASSED"
exit 0

//--- src/channel_rx_arbiter.sv
// channel_rx_arbiter module, round robin packet locked merge of the channel response streams
`timescale 1ns/1ps

module channel_rx_arbiter #(
    parameter int N_CHAN = 5  // channel streams merged
) (
    input  logic                clk,
    input  logic                rst_n,
    input  wfd_pkg::chan_mask_t in_valid,          // per channel requests
    input  wfd_pkg::chan_beat_t in_beat [N_CHAN],  // per channel beats
    output wfd_pkg::chan_mask_t in_ready,          // only the owner sees ready
    output logic                out_valid,
    output wfd_pkg::chan_beat_t out_beat,
    input  logic                out_ready
);

    localparam int IDX_W = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

    logic [IDX_W-1:0] grant;      // channel owning the output
    logic             locked;     // a packet is in progress
    logic [IDX_W-1:0] start_ptr;  // first channel looked at by the search
    logic [IDX_W-1:0] pick;       // search winner
    logic             found;
    logic             pkt_end;    // last beat of the owner moves this cycle

    ////////////////////////////////////////////////////////////
    // round robin search
    ////////////////////////////////////////////////////////////

    always_comb begin
        int j;
        found = 1'b0;
        pick  = start_ptr;
        for (int k = 0; k < N_CHAN; k++) begin
            j = (int'(start_ptr) + k) % N_CHAN;  // walk upward with wrap
            if (!found && in_valid[j]) begin
                found = 1'b1;
                pick  = IDX_W'(j);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // grant register
    ////////////////////////////////////////////////////////////

    assign pkt_end = out_valid & out_ready & out_beat.last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant     <= '0;
            locked    <= 1'b0;
            start_ptr <= '0;            // channel 0 goes first after reset
        end else if (!locked) begin
            if (found) begin
                grant  <= pick;         // takes effect next cycle
                locked <= 1'b1;
                // next search begins one past this owner
                start_ptr <= (pick == IDX_W'(N_CHAN - 1)) ? '0 : pick + 1'b1;
            end
        end else if (pkt_end) begin
            locked <= 1'b0;             // packet done, release
        end
    end

    ////////////////////////////////////////////////////////////
    // output mux, zero latency once granted
    ////////////////////////////////////////////////////////////

    assign out_valid = locked & in_valid[grant];
    assign out_beat  = in_beat[grant];

    always_comb begin
        in_ready = '0;
        in_ready[grant] = locked & out_ready;  // hold everyone else off
    end

endmodule

//--- src/channel_tx_router.sv
// channel_tx_router module, steers command beats to one channel by their destination field
`timescale 1ns/1ps

module channel_tx_router #(
    parameter int N_CHAN = 5  // channels behind the router
) (
    input  logic                in_valid,
    input  wfd_pkg::cmd_beat_t  in_beat,    // head of the command fifo
    output logic                in_ready,
    output wfd_pkg::chan_mask_t out_valid,  // one hot on the target channel
    output wfd_pkg::chan_beat_t out_beat,   // shared by all channels
    input  wfd_pkg::chan_mask_t out_ready
);

    logic dest_hit;  // dest names an existing channel
    logic sel_ready; // ready of that channel

    ////////////////////////////////////////////////////////////
    // dest decode, purely combinational
    ////////////////////////////////////////////////////////////

    always_comb begin
        out_valid = '0;
        dest_hit  = 1'b0;
        sel_ready = 1'b0;
        for (int i = 0; i < N_CHAN; i++) begin
            if (in_beat.dest == wfd_pkg::DEST_W'(i)) begin
                out_valid[i] = in_valid;      // only the addressed channel sees it
                dest_hit     = 1'b1;
                sel_ready    = out_ready[i];
            end
        end
    end

    // back pressure of the target passes straight to the fifo
    // beats for a missing channel are swallowed
    assign in_ready = dest_hit ? sel_ready : 1'b1;

    // dest stripped, data and last untouched
    assign out_beat.data = in_beat.data;
    assign out_beat.last = in_beat.last;

endmodule

//--- src/stream_fifo.sv
// stream_fifo module, first word fall through valid/ready fifo with a payload type parameter
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic [31:0],  // beat carried by the fifo
    parameter int  DEPTH     = 8              // number of entries
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,   // low only when full
    output logic     out_valid,
    output payload_t out_data,   // head entry, valid while not empty
    input  logic     out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);  // count runs 0 to DEPTH

    payload_t         mem [DEPTH];  // circular buffer
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;        // entries held
    logic             do_wr;
    logic             do_rd;

    // pointer step with wrap, works for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];         // head shows the cycle after its write
    assign do_wr     = in_valid & in_ready;
    assign do_rd     = out_valid & out_ready;

    // storage
    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= in_data;
    end

    // pointers and fill count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;  // write only
                2'b01:   count <= count - 1'b1;  // read only
                default: count <= count;         // both or neither
            endcase
        end
    end

endmodule

//--- src/trigger_manager.sv
// trigger_manager module with go pulse, sticky done collection and trigger numbering
`timescale 1ns/1ps

module trigger_manager (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                trigger,     // strobe from the host side
    input  wfd_pkg::chan_mask_t done,        // done levels from the channel fpgas
    output wfd_pkg::chan_mask_t go,          // acquisition start, one cycle wide
    output logic                busy,        // high from go until the number is pushed
    output logic                push_valid,  // trigger number offered to the fifo
    output wfd_pkg::trig_num_t  push_num,
    input  logic                push_ready
);

    ////////////////////////////////////////////////////////////
    // state and counters
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_IDLE,       // waiting for a trigger
        ST_WAIT_DONE,  // go sent, collecting done levels
        ST_PUSH        // all done, holding the number for the fifo
    } state_t;

    state_t              state;
    wfd_pkg::chan_mask_t done_seen;  // sticky done bits for this trigger
    wfd_pkg::trig_num_t  trig_cnt;   // number of the trigger in flight

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            go        <= '0;
            done_seen <= '0;
            trig_cnt  <= wfd_pkg::trig_num_t'(1);  // first trigger is number 1
        end else begin
            go <= '0;  // go is a single cycle strobe
            case (state)
                ST_IDLE: begin
                    if (trigger) begin
                        go        <= '1;          // fire every channel at once
                        done_seen <= '0;          // forget the previous trigger
                        state     <= ST_WAIT_DONE;
                    end
                end
                ST_WAIT_DONE: begin
                    // only levels seen after go count
                    done_seen <= done_seen | done;
                    if (&done_seen)
                        state <= ST_PUSH;         // offer the number one cycle later
                end
                ST_PUSH: begin
                    if (push_ready) begin         // fifo took it, back to idle
                        trig_cnt <= trig_cnt + 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    // triggers arriving while busy fall on the floor
    assign busy       = (state != ST_IDLE);
    assign push_valid = (state == ST_PUSH);   // held until accepted
    assign push_num   = trig_cnt;             // stable for the whole push

endmodule

//--- src/wfd_master_core.sv
// wfd_master_core module, top level wiring the trigger path and both channel stream paths
`timescale 1ns/1ps

module wfd_master_core #(
    parameter int TRIG_FIFO_DEPTH = 8,   // trigger numbers waiting for readout
    parameter int CMD_FIFO_DEPTH  = 16   // host command beats buffered
) (
    input  logic                clk,
    input  logic                rst_n,
    // trigger and channel control
    input  logic                trigger,
    output wfd_pkg::chan_mask_t acq_trigs,       // go pulse to the channel fpgas
    input  wfd_pkg::chan_mask_t acq_dones,
    output logic                busy,
    // trigger number stream
    output logic                trig_num_valid,
    output wfd_pkg::trig_num_t  trig_num,
    input  logic                trig_num_ready,
    // host commands
    input  logic                cmd_valid,
    input  wfd_pkg::cmd_beat_t  cmd,
    output logic                cmd_ready,
    // commands to the channels
    output wfd_pkg::chan_mask_t chan_tx_valid,
    output wfd_pkg::chan_beat_t chan_tx,         // common beat, qualified by valid
    input  wfd_pkg::chan_mask_t chan_tx_ready,
    // responses from the channels
    input  wfd_pkg::chan_mask_t chan_rx_valid,
    input  wfd_pkg::chan_beat_t chan_rx_data [wfd_pkg::NUM_CHANNELS],
    output wfd_pkg::chan_mask_t chan_rx_ready,
    // merged response
    output logic                resp_valid,
    output wfd_pkg::chan_beat_t resp,
    input  logic                resp_ready
);

    ////////////////////////////////////////////////////////////
    // trigger path
    ////////////////////////////////////////////////////////////

    logic               tm_push_valid;  // manager to trigger number fifo
    logic               tm_push_ready;
    wfd_pkg::trig_num_t tm_push_num;

    trigger_manager tm (
        .clk        (clk),
        .rst_n      (rst_n),
        .trigger    (trigger),
        .done       (acq_dones),
        .go         (acq_trigs),
        .busy       (busy),          // stretched while the fifo is full
        .push_valid (tm_push_valid),
        .push_num   (tm_push_num),
        .push_ready (tm_push_ready)
    );

    stream_fifo #(
        .payload_t (wfd_pkg::trig_num_t),
        .DEPTH     (TRIG_FIFO_DEPTH)
    ) trig_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (tm_push_valid),
        .in_data   (tm_push_num),
        .in_ready  (tm_push_ready),
        .out_valid (trig_num_valid),
        .out_data  (trig_num),
        .out_ready (trig_num_ready)
    );

    ////////////////////////////////////////////////////////////
    // command path, fifo then router
    ////////////////////////////////////////////////////////////

    logic               cf_valid;  // fifo head to router
    logic               cf_ready;
    wfd_pkg::cmd_beat_t cf_beat;

    stream_fifo #(
        .payload_t (wfd_pkg::cmd_beat_t),
        .DEPTH     (CMD_FIFO_DEPTH)
    ) cmd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (cmd_valid),
        .in_data   (cmd),
        .in_ready  (cmd_ready),
        .out_valid (cf_valid),
        .out_data  (cf_beat),
        .out_ready (cf_ready)
    );

    channel_tx_router #(
        .N_CHAN (wfd_pkg::NUM_CHANNELS)
    ) tx_router (
        .in_valid  (cf_valid),
        .in_beat   (cf_beat),
        .in_ready  (cf_ready),
        .out_valid (chan_tx_valid),
        .out_beat  (chan_tx),
        .out_ready (chan_tx_ready)
    );

    ////////////////////////////////////////////////////////////
    // response path
    ////////////////////////////////////////////////////////////

    channel_rx_arbiter #(
        .N_CHAN (wfd_pkg::NUM_CHANNELS)
    ) rx_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (chan_rx_valid),
        .in_beat   (chan_rx_data),
        .in_ready  (chan_rx_ready),
        .out_valid (resp_valid),
        .out_beat  (resp),
        .out_ready (resp_ready)
    );

endmodule

//--- src/wfd_pkg.sv
// wfd_pkg package with board constants, channel mask, trigger number and stream beat structs
package wfd_pkg;

    ////////////////////////////////////////////////////////////
    // board constants
    ////////////////////////////////////////////////////////////

    localparam int NUM_CHANNELS = 5;   // channel fpgas driven by the master
    localparam int DATA_W       = 32;  // width of every stream word
    localparam int DEST_W       = 4;   // destination field of a host command
    localparam int TRIG_NUM_W   = 24;  // trigger counter width

    ////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////

    // one bit per channel, used for go, done and per channel valid/ready
    typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

    // running trigger number handed to the readout side
    typedef logic [TRIG_NUM_W-1:0] trig_num_t;

    // one command beat from the host, 37 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;   // command word
        logic [DEST_W-1:0] dest;   // target channel index
        logic              last;   // closes the command packet
    } cmd_beat_t;

    // one beat of a channel stream or of the merged response, 33 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;   // payload word
        logic              last;   // closes the packet
    } chan_beat_t;

    // beats leaving the router lose only their dest field, so the
    // channel beat is the command beat with dest stripped off
    // data keeps the msb side in both structs

endpackage

//--- tests/tb_tasks.svh
// testbench compare task, clock helpers, trigger and stream helpers and the directed tests
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////////////////////////////////////////////
// common helpers
////////////////////////////////////////////////////////////

task automatic check_val(input string test, input string what,
                         input logic [63:0] exp, input logic [63:0] act);
    chk_cnt++;
    if (exp !== act) begin
        err_cnt++;
        $display("ERR %s: %s expected %0h actual %0h", test, what, exp, act);
    end
endtask

task automatic report_fail(input string test, input string msg);
    err_cnt++;
    $display("%s: %s", test, msg);  // non value failure, plain words
endtask

task automatic drive_edge();   // inputs change 1 ns past the rising edge
    @(posedge clk);
    #1;
endtask

task automatic sample_edge();  // outputs read on the falling edge
    @(negedge clk);
endtask

task automatic finish_test(input string test, input int errs_before);
    test_cnt++;
    $display("%s done, %0d errors", test, err_cnt - errs_before);
endtask

// strobe, go pulse, dones out of order, then wait for idle
task automatic complete_trigger(input string test, input bit poke_busy);
    int ch;
    int wait_cyc;
    trigger = 1'b1;
    drive_edge();
    trigger = 1'b0;
    sample_edge();
    check_val(test, "go", (1 << NCH) - 1, acq_trigs);  // every channel fires
    check_val(test, "busy", 1, busy);
    drive_edge();
    sample_edge();
    check_val(test, "go width", 0, acq_trigs);         // single cycle
    drive_edge();
    if (poke_busy) begin
        trigger = 1'b1;                                // must be ignored
        drive_edge();
        trigger = 1'b0;
        sample_edge();
        check_val(test, "go while busy", 0, acq_trigs);
        drive_edge();
    end
    // step two from a moving start, so each channel once and scrambled
    for (int s = 0; s < NCH; s++) begin
        ch = (next_num + 2 * s) % NCH;
        acq_dones[ch] = 1'b1;
        repeat (1 + ($unsigned($random(seed)) % 2)) drive_edge();
    end
    acq_dones = '0;
    wait_cyc  = 0;
    sample_edge();
    while (busy && wait_cyc < 20) begin
        drive_edge();
        sample_edge();
        wait_cyc++;
    end
    if (busy)
        report_fail(test, "busy stayed high after all channels were done");
    drive_edge();
    next_num++;
endtask

// one trigger number off the stream, ready up for a single beat
task automatic pop_trig_num(input string test, output wfd_pkg::trig_num_t num);
    int wait_cyc;
    wait_cyc       = 0;
    trig_num_ready = 1'b1;
    sample_edge();
    while (!trig_num_valid && wait_cyc < 20) begin
        drive_edge();
        sample_edge();
        wait_cyc++;
    end
    if (!trig_num_valid)
        report_fail(test, "no trigger number was offered");
    num = trig_num;
    drive_edge();                  // beat leaves on this edge
    trig_num_ready = 1'b0;
endtask

////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////

task automatic reset_outputs_low();
    string tn;
    int    errs;
    tn   = "reset_outputs_low";
    errs = err_cnt;
    sample_edge();
    check_val(tn, "acq_trigs", 0, acq_trigs);
    check_val(tn, "busy", 0, busy);
    check_val(tn, "trig_num_valid", 0, trig_num_valid);
    check_val(tn, "chan_tx_valid", 0, chan_tx_valid);
    check_val(tn, "chan_rx_ready", 0, chan_rx_ready);
    check_val(tn, "resp_valid", 0, resp_valid);
    drive_edge();
    finish_test(tn, errs);
endtask

task automatic trigger_numbering();
    string              tn;
    int                 errs;
    int                 exp_num;
    wfd_pkg::trig_num_t num;
    tn   = "trigger_numbering";
    errs = err_cnt;
    for (int t = 0; t < 3; t++) begin
        exp_num = next_num;
        complete_trigger(tn, t == 1);  // second trigger also gets a stray strobe
        pop_trig_num(tn, num);
        check_val(tn, "number", exp_num, num);
    end
    sample_edge();
    check_val(tn, "extra number", 0, trig_num_valid);
    drive_edge();
    finish_test(tn, errs);
endtask

task automatic trigger_fifo_backpressure();
    string              tn;
    int                 errs;
    int                 first;
    wfd_pkg::trig_num_t num;
    tn    = "trigger_fifo_backpressure";
    errs  = err_cnt;
    first = next_num;
    for (int t = 0; t < 5; t++) begin
        complete_trigger(tn, 1'b0);    // readout stalled throughout
    end
    for (int t = 0; t < 5; t++) begin
        pop_trig_num(tn, num);
        check_val(tn, "number", first + t, num);
    end
    sample_edge();
    check_val(tn, "extra number", 0, trig_num_valid);
    drive_edge();
    finish_test(tn, errs);
endtask

task automatic command_routing();
    string              tn;
    int                 errs;
    int                 wait_cyc;
    wfd_pkg::cmd_beat_t beat;
    wfd_pkg::cmd_beat_t exp;
    wfd_pkg::cmd_beat_t sent [$];
    tn   = "command_routing";
    errs = err_cnt;
    // thirteen beats queued while channels stall, beat 6 has no channel
    for (int i = 0; i < 13; i++) begin
        beat.data = $random(seed);
        beat.dest = (i == 6) ? 4'd7 : wfd_pkg::DEST_W'($unsigned($random(seed)) % NCH);
        beat.last = 1'($random(seed));
        cmd       = beat;
        cmd_valid = 1'b1;
        wait_cyc  = 0;
        sample_edge();
        while (!cmd_ready && wait_cyc < 20) begin
            drive_edge();
            sample_edge();
            wait_cyc++;
        end
        if (!cmd_ready)
            report_fail(tn, "command FIFO never accepted a beat");
        drive_edge();
        if (beat.dest < NCH)
            sent.push_back(beat);
    end
    cmd_valid = 1'b0;
    wait_cyc  = 0;
    while (sent.size() > 0 && wait_cyc < 200) begin
        chan_tx_ready = wfd_pkg::chan_mask_t'($random(seed));  // random stalls
        sample_edge();
        if (chan_tx_valid != '0) begin
            exp = sent[0];
            check_val(tn, "valid", 1 << exp.dest, chan_tx_valid);
            check_val(tn, "data", exp.data, chan_tx.data);
            check_val(tn, "last", exp.last, chan_tx.last);
            if ((chan_tx_valid & chan_tx_ready) != '0)
                void'(sent.pop_front());
        end
        drive_edge();
        wait_cyc++;
    end
    if (sent.size() > 0)
        report_fail(tn, "some command beats never reached their channel");
    chan_tx_ready = '1;
    repeat (3) begin
        sample_edge();
        check_val(tn, "valid after drain", 0, chan_tx_valid);  // dead letter gone
        drive_edge();
    end
    chan_tx_ready = '0;
    finish_test(tn, errs);
endtask

task automatic response_merging();
    string               tn;
    int                  errs;
    int                  wait_cyc;
    int                  ptr [NCH];
    wfd_pkg::chan_beat_t pkt [NCH][3];
    wfd_pkg::chan_beat_t exp;
    wfd_pkg::chan_beat_t merged [$];
    tn   = "response_merging";
    errs = err_cnt;
    for (int c = 0; c < NCH; c++) begin
        ptr[c] = 3;                    // 3 means nothing left to send
        for (int b = 0; b < 3; b++) begin
            pkt[c][b].data = $random(seed);
            pkt[c][b].last = (b == 2);
        end
    end
    ptr[1] = 0;
    ptr[3] = 0;
    // search starts at channel 0, so channel 1 goes out whole before 3
    for (int b = 0; b < 3; b++) begin
        merged.push_back(pkt[1][b]);
    end
    for (int b = 0; b < 3; b++) begin
        merged.push_back(pkt[3][b]);
    end
    wait_cyc = 0;
    while (merged.size() > 0 && wait_cyc < 100) begin
        for (int c = 0; c < NCH; c++) begin
            chan_rx_valid[c] = (ptr[c] < 3);
            if (ptr[c] < 3)
                chan_rx_data[c] = pkt[c][ptr[c]];
            else
                chan_rx_data[c] = '0;
        end
        resp_ready = 1'($random(seed));
        sample_edge();
        for (int c = 0; c < NCH; c++) begin
            if (chan_rx_valid[c] && chan_rx_ready[c])
                ptr[c]++;                // beat taken on the coming edge
        end
        if (resp_valid && resp_ready) begin
            exp = merged.pop_front();
            check_val(tn, "data", exp.data, resp.data);
            check_val(tn, "last", exp.last, resp.last);
        end
        drive_edge();
        wait_cyc++;
    end
    if (merged.size() > 0)
        report_fail(tn, "merged stream stopped before both packets were out");
    chan_rx_valid = '0;
    resp_ready    = 1'b1;            // a lock left behind would show as ready to its owner
    sample_edge();
    check_val(tn, "resp_valid idle", 0, resp_valid);
    check_val(tn, "chan_rx_ready idle", 0, chan_rx_ready);
    drive_edge();
    resp_ready = 1'b0;
    finish_test(tn, errs);
endtask

`endif

//--- tests/tb_wfd_master_core.sv
// tb_wfd_master_core testbench top with clock, reset, DUT instance, timeout and test sequence
`timescale 1ns/1ps

module tb_wfd_master_core;

    localparam int NCH        = wfd_pkg::NUM_CHANNELS;
    localparam int MAX_CYCLES = 4000;  // whole sequence needs a few hundred cycles

    ////////////////////////////////////////////////////////////
    // DUT signals
    ////////////////////////////////////////////////////////////

    logic                clk = 1'b0;
    logic                rst_n;
    logic                trigger;
    wfd_pkg::chan_mask_t acq_trigs;
    wfd_pkg::chan_mask_t acq_dones;
    logic                busy;
    logic                trig_num_valid;
    wfd_pkg::trig_num_t  trig_num;
    logic                trig_num_ready;
    logic                cmd_valid;
    wfd_pkg::cmd_beat_t  cmd;
    logic                cmd_ready;
    wfd_pkg::chan_mask_t chan_tx_valid;
    wfd_pkg::chan_beat_t chan_tx;
    wfd_pkg::chan_mask_t chan_tx_ready;
    wfd_pkg::chan_mask_t chan_rx_valid;
    wfd_pkg::chan_beat_t chan_rx_data [NCH];
    wfd_pkg::chan_mask_t chan_rx_ready;
    logic                resp_valid;
    wfd_pkg::chan_beat_t resp;
    logic                resp_ready;

    int seed      = 82667;  // $random seed
    int err_cnt   = 0;
    int chk_cnt   = 0;
    int test_cnt  = 0;
    int cycle_cnt = 0;
    int next_num  = 1;      // number the next completed trigger should carry

    always #2 clk = ~clk;   // 4 ns period

    wfd_master_core #(
        .TRIG_FIFO_DEPTH (8),
        .CMD_FIFO_DEPTH  (16)
    ) UUT (.*);

    // hard stop in case a handshake never completes
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the tests did not end within %0d clock cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    `include "tb_tasks.svh"

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n          = 1'b0;
        trigger        = 1'b0;
        acq_dones      = '0;
        trig_num_ready = 1'b0;
        cmd_valid      = 1'b0;
        cmd            = '0;
        chan_tx_ready  = '0;
        chan_rx_valid  = '0;
        resp_ready     = 1'b0;
        for (int c = 0; c < NCH; c++) begin
            chan_rx_data[c] = '0;
        end
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;             // release just past the edge like any input

        reset_outputs_low();
        trigger_numbering();
        trigger_fifo_backpressure();
        command_routing();
        response_merging();

        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule
